// ==== verilog.f ====
common/gs_pkg.sv
common/gs_row_if.sv
row_engine/gs_dot_product.sv
row_engine/gs_row_update.sv
source/gs_sequencer.sv
source/gs_solver_top.sv
sim/gs_solver_tb.sv

// ==== Bender.yml ====
package:
  name: gs_solver

sources:
  - common/gs_pkg.sv
  - common/gs_row_if.sv
  - row_engine/gs_dot_product.sv
  - row_engine/gs_row_update.sv
  - source/gs_sequencer.sv
  - source/gs_solver_top.sv
  - target: simulation
    files:
      - sim/gs_solver_tb.sv

// ==== sim/gs_solver_tb.sv ====
// gs_solver_tb: Gauss-Seidel solver testbench with random latency memory, reference model, checks
`timescale 1ns/1ps

module gs_solver_tb import gs_pkg::*; ();

	localparam int CLK_HALF       = 10;
	localparam int READS_PER_MAT  = 1 + N_DIM * ITER_COUNT;  // b, then 16 sweeps of 16 rows
	localparam int TIMEOUT_CYCLES = 4 * 273 * 10 + 2000;     // four matrices over both runs

	logic                  i_clk = 1'b0;
	logic                  i_reset;
	logic                  i_module_en;
	logic [MAT_W-1:0]      i_matrix_num;
	logic                  i_mem_rrdy;
	mem_word_t             i_mem_dout;
	logic                  i_mem_dout_vld;
	logic                  o_proc_done;
	logic                  o_mem_rreq;
	logic [MEM_ADDR_W-1:0] o_mem_addr;
	logic                  o_x_wen;
	logic [X_ADDR_W-1:0]   o_x_addr;
	logic [X_W-1:0]        o_x_data;

	mem_word_t   mem [1 << MEM_ADDR_W];
	int          exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] rng_state = 32'hac39_1f3b;
	int          data_errs  = 0;
	int          addr_errs  = 0;
	int          proto_errs = 0;
	int          cycle_cnt  = 0;
	int          rd_idx     = 0;   // reads accepted in this run
	int          clamp_cnt  = 0;
	logic        clamp_run  = 1'b0;
	logic        pending    = 1'b0;
	int          lat_left;
	int          rd_addr;

	gs_solver_top uut (.*);

	initial begin
		forever #(CLK_HALF) i_clk = ~i_clk;
	end

	// ---------------------------------------------------------------------------
	// random numbers and reference arithmetic
	// ---------------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int draw(input int lo, input int hi);
		rng_state = lcg_next(rng_state);
		return lo + int'(rng_state[31:16]) % (hi - lo + 1);  // upper half of the LCG state
	endfunction

	function automatic longint lane(input mem_word_t w, input int j);
		logic signed [ELEM_W-1:0] e;
		e = w[j*ELEM_W +: ELEM_W];
		return longint'(e);
	endfunction

	function automatic longint clamp32(input longint v);
		if (v > 64'sd2147483647) begin
			return 64'sd2147483647;
		end
		if (v < -64'sd2147483648) begin
			return -64'sd2147483648;
		end
		return v;
	endfunction

	// word address of the k-th read of a run
	function automatic int expect_addr(input int k);
		int m;
		int r;
		m = k / READS_PER_MAT;
		r = k % READS_PER_MAT;
		if (r == 0) begin
			return m * WORDS_PER_MAT + B_WORD;
		end
		return m * WORDS_PER_MAT + (r - 1) % N_DIM;
	endfunction

	// full fixed-count solve of one matrix, queues the final sweep results
	task automatic ref_solve(input int m);
		longint    x [N_DIM];
		longint    sum;
		longint    resid;
		mem_word_t bw;
		mem_word_t rw;
		bw = mem[m*WORDS_PER_MAT + B_WORD];
		for (int i = 0; i < N_DIM; i++) begin
			x[i] = 0;
		end
		for (int it = 0; it < ITER_COUNT; it++) begin
			for (int i = 0; i < N_DIM; i++) begin
				rw  = mem[m*WORDS_PER_MAT + i];
				sum = 0;
				for (int j = 0; j < N_DIM; j++) begin
					if (j != i) begin
						sum += lane(rw, j) * x[j];
					end
				end
				resid = clamp32((lane(bw, i) <<< FRAC_W) - sum);
				x[i]  = clamp32((resid * lane(rw, i)) >>> INV_SHIFT);  // newest x right away
				if (it == ITER_COUNT - 1) begin
					exp_addr_q.push_back(m * N_DIM + i);
					exp_data_q.push_back(32'(x[i]));
				end
			end
		end
	endtask

	// ---------------------------------------------------------------------------
	// stimulus data
	// ---------------------------------------------------------------------------
	// three diagonally dominant systems, diagonal already holds 2^14 / a_ii
	task automatic fill_matrices();
		int inv;
		for (int m = 0; m < 3; m++) begin
			for (int i = 0; i < N_DIM; i++) begin
				inv = draw(100, 200);  // a_ii roughly 80 to 160
				if (draw(0, 1) == 1) begin
					inv = -inv;
				end
				for (int j = 0; j < N_DIM; j++) begin
					if (j == i) begin
						mem[m*WORDS_PER_MAT + i][j*ELEM_W +: ELEM_W] = 16'(inv);
					end
					else begin
						mem[m*WORDS_PER_MAT + i][j*ELEM_W +: ELEM_W] = 16'(draw(-4, 4));
					end
				end
				mem[m*WORDS_PER_MAT + B_WORD][i*ELEM_W +: ELEM_W] = 16'(draw(-2048, 2047));
			end
		end
	endtask

	// matrix 0 rebuilt so that even rows clamp high and odd rows clamp low
	task automatic load_clamp_matrix();
		for (int i = 0; i < N_DIM; i++) begin
			mem[i] = '0;
			mem[i][i*ELEM_W +: ELEM_W]       = 16'sh7fff;  // reciprocal near 2.0
			mem[i][(i ^ 1)*ELEM_W +: ELEM_W] = 16'sh0001;  // couples row pairs
			mem[B_WORD][i*ELEM_W +: ELEM_W]  = (i % 2 == 0) ? 16'sh7fff : 16'sh8000;
		end
	endtask

	// ---------------------------------------------------------------------------
	// memory model, one read outstanding, random ready and latency
	// ---------------------------------------------------------------------------
	always @(negedge i_clk) begin
		if (i_reset) begin
			pending        = 1'b0;
			i_mem_rrdy     = 1'b0;
			i_mem_dout_vld = 1'b0;
		end
		else begin
			i_mem_dout_vld = 1'b0;
			if (pending) begin
				assert (!o_mem_rreq) else begin
					proto_errs++;
					$display("new read request at %0t while a read is still outstanding", $time);
				end
				lat_left--;
				if (lat_left == 0) begin
					i_mem_dout     = mem[rd_addr];
					i_mem_dout_vld = 1'b1;
					pending        = 1'b0;
				end
			end
			i_mem_rrdy = (draw(0, 3) != 0);  // stall one cycle in four
			if (!pending && o_mem_rreq && i_mem_rrdy) begin
				assert (int'(o_mem_addr) == expect_addr(rd_idx)) else begin
					addr_errs++;
					$display("Fail at %0t: o_mem_addr expected %0d got %0d", $time,
						expect_addr(rd_idx), o_mem_addr);
				end
				rd_addr  = int'(o_mem_addr);
				lat_left = draw(1, 8);
				pending  = 1'b1;
				rd_idx++;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// result writes and done flag
	// ---------------------------------------------------------------------------
	always @(negedge i_clk) begin : write_check
		int          exp_addr;
		logic [31:0] exp_data;
		if (!i_reset && o_x_wen) begin
			assert (exp_addr_q.size() > 0) else begin
				addr_errs++;
				$display("result write at %0t when no result was left to write", $time);
			end
			if (exp_addr_q.size() > 0) begin
				exp_addr = exp_addr_q.pop_front();
				exp_data = exp_data_q.pop_front();
				assert (int'(o_x_addr) == exp_addr) else begin
					addr_errs++;
					$display("Fail at %0t: o_x_addr expected %0d got %0d", $time, exp_addr,
						o_x_addr);
				end
				assert (o_x_data == exp_data) else begin
					data_errs++;
					$display("Fail at %0t: o_x_data expected %h got %h", $time, exp_data,
						o_x_data);
				end
				if (clamp_run && (o_x_data == X_MAX || o_x_data == X_MIN)) begin
					clamp_cnt++;
				end
			end
		end
		if (!i_reset && o_proc_done) begin
			assert (exp_addr_q.size() == 0) else begin
				proto_errs++;
				$display("done high at %0t with %0d results still unwritten", $time,
					exp_addr_q.size());
			end
		end
	end

	a_req_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mem_rreq && !i_mem_rrdy |=> o_mem_rreq && $stable(o_mem_addr))
	else begin
		proto_errs++;
		$display("read request or address changed at %0t before the memory was ready", $time);
	end

	a_req_drop: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mem_rreq && i_mem_rrdy |=> !o_mem_rreq)
	else begin
		proto_errs++;
		$display("read request still high at %0t after it was accepted", $time);
	end

	a_done_drop: assert property (@(posedge i_clk) disable iff (i_reset)
		o_proc_done && !i_module_en |=> !o_proc_done)
	else begin
		proto_errs++;
		$display("done still high at %0t one cycle after enable fell", $time);
	end

	// ---------------------------------------------------------------------------
	// sequence and run control
	// ---------------------------------------------------------------------------
	task automatic check_idle(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge i_clk);
			assert (!o_mem_rreq && !o_x_wen && !o_proc_done) else begin
				proto_errs++;
				$display("request, write or done active at %0t while idle", $time);
			end
		end
	endtask

	task automatic run_solver(input int n, input logic clamp);
		rd_idx    = 0;
		clamp_cnt = 0;
		clamp_run = clamp;
		for (int m = 0; m < n; m++) begin
			ref_solve(m);
		end
		i_matrix_num = MAT_W'(n);
		i_module_en  = 1'b1;
		while (!o_proc_done) begin
			@(negedge i_clk);
		end
		assert (rd_idx == n * READS_PER_MAT) else begin
			addr_errs++;
			$display("%0d memory reads accepted, %0d expected", rd_idx, n * READS_PER_MAT);
		end
		repeat (5) begin  // done must hold while enabled
			@(negedge i_clk);
			assert (o_proc_done) else begin
				proto_errs++;
				$display("done fell at %0t while enable was still high", $time);
			end
		end
		i_module_en = 1'b0;
		@(negedge i_clk);
		assert (!o_proc_done) else begin
			proto_errs++;
			$display("done did not fall at %0t after enable dropped", $time);
		end
	endtask

	task automatic report_counts();
		$display("error counts: data %0d, address %0d, protocol %0d", data_errs, addr_errs,
			proto_errs);
	endtask

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the solver never finished", cycle_cnt);
			report_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		i_reset        = 1'b1;
		i_module_en    = 1'b0;
		i_matrix_num   = '0;
		i_mem_rrdy     = 1'b0;
		i_mem_dout     = '0;
		i_mem_dout_vld = 1'b0;
		fill_matrices();
		check_idle(3);
		i_reset = 1'b0;
		check_idle(4);

		run_solver(3, 1'b0);
		check_idle(4);

		// second enable, one matrix that saturates
		load_clamp_matrix();
		run_solver(1, 1'b1);
		assert (clamp_cnt == N_DIM) else begin
			data_errs++;
			$display("only %0d of %0d results of the clamp matrix hit a limit", clamp_cnt,
				N_DIM);
		end
		check_idle(2);

		report_counts();
		if (data_errs + addr_errs + proto_errs == 0) begin
			$display("TEST RESULT: PASS");
		end
		else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== source/gs_solver_top.sv ====
// gs_solver_top: iterative Gauss-Seidel solver for 16x16 systems held in matrix memory
`timescale 1ns/1ps

module gs_solver_top import gs_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_module_en,
	input  logic [MAT_W-1:0]      i_matrix_num,
	output logic                  o_proc_done,

	// matrix memory
	output logic                  o_mem_rreq,
	output logic [MEM_ADDR_W-1:0] o_mem_addr,
	input  logic                  i_mem_rrdy,
	input  mem_word_t             i_mem_dout,
	input  logic                  i_mem_dout_vld,

	// result port
	output logic                  o_x_wen,
	output logic [X_ADDR_W-1:0]   o_x_addr,
	output logic [X_W-1:0]        o_x_data
);

	// ---------------------------------------------------------------------------
	// fetched words from the sequencer to the row engine
	// ---------------------------------------------------------------------------
	gs_row_if row_bus ();

	gs_sequencer u_sequencer (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_module_en    (i_module_en),
		.i_matrix_num   (i_matrix_num),
		.i_mem_rrdy     (i_mem_rrdy),
		.i_mem_dout     (i_mem_dout),
		.i_mem_dout_vld (i_mem_dout_vld),
		.o_mem_rreq     (o_mem_rreq),
		.o_mem_addr     (o_mem_addr),
		.o_proc_done    (o_proc_done),
		.row            (row_bus)
	);

	// ---------------------------------------------------------------------------
	// arithmetic and x storage
	// ---------------------------------------------------------------------------
	gs_row_update u_row_update (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.row      (row_bus),
		.o_x_wen  (o_x_wen),
		.o_x_addr (o_x_addr),
		.o_x_data (o_x_data)
	);

endmodule

// ==== source/gs_sequencer.sv ====
// gs_sequencer: read FSM with matrix, sweep and row counters, memory addressing and done flag
`timescale 1ns/1ps

module gs_sequencer import gs_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_module_en,
	input  logic [MAT_W-1:0]      i_matrix_num,
	input  logic                  i_mem_rrdy,
	input  mem_word_t             i_mem_dout,
	input  logic                  i_mem_dout_vld,
	output logic                  o_mem_rreq,
	output logic [MEM_ADDR_W-1:0] o_mem_addr,
	output logic                  o_proc_done,
	gs_row_if.seq                 row
);

	seq_state_t state_r, state_w;

	logic [MAT_W-1:0]              mat_cnt_r;
	logic [$clog2(ITER_COUNT)-1:0] iter_cnt_r;
	logic [ROW_W-1:0]              row_cnt_r;
	logic                          b_loaded_r;  // b of this matrix already read

	logic                  word_vld;
	logic                  last_row;
	logic                  last_iter;
	logic                  last_mat;
	logic                  mat_end;
	logic [MEM_ADDR_W-1:0] mat_base;

	// ---------------------------------------------------------------------------
	// status decode
	// ---------------------------------------------------------------------------
	assign word_vld  = (state_r == ST_WAIT) && i_mem_dout_vld;
	assign last_row  = int'(row_cnt_r) == N_DIM - 1;
	assign last_iter = int'(iter_cnt_r) == ITER_COUNT - 1;
	assign last_mat  = mat_cnt_r == i_matrix_num - 1'b1;
	assign mat_end   = b_loaded_r && last_row && last_iter;  // last row of last sweep

	// word address: matrix * 17, then b or the row
	assign mat_base   = MEM_ADDR_W'(mat_cnt_r) * MEM_ADDR_W'(WORDS_PER_MAT);
	assign o_mem_addr = b_loaded_r ? mat_base + MEM_ADDR_W'(row_cnt_r)
	                               : mat_base + MEM_ADDR_W'(B_WORD);

	assign o_mem_rreq  = (state_r == ST_REQ);
	assign o_proc_done = (state_r == ST_FINISH);

	// returned word goes straight to the row engine
	assign row.vld       = word_vld;
	assign row.kind      = b_loaded_r ? WORD_ROW : WORD_B;
	assign row.row_idx   = row_cnt_r;
	assign row.mat_idx   = mat_cnt_r;
	assign row.last_iter = last_iter;
	assign row.data      = i_mem_dout;

	// ---------------------------------------------------------------------------
	// FSM
	// ---------------------------------------------------------------------------
	always_comb begin
		state_w = state_r;
		case (state_r)
			ST_IDLE: begin
				if (i_module_en) begin
					state_w = ST_REQ;
				end
			end
			ST_REQ: begin
				if (i_mem_rrdy) begin  // request accepted
					state_w = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (i_mem_dout_vld) begin
					state_w = (mat_end && last_mat) ? ST_FINISH : ST_REQ;
				end
			end
			ST_FINISH: begin
				if (!i_module_en) begin
					state_w = ST_IDLE;
				end
			end
			default: state_w = ST_IDLE;
		endcase
	end

	// ---------------------------------------------------------------------------
	// counters
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state_r    <= ST_IDLE;
			mat_cnt_r  <= '0;
			iter_cnt_r <= '0;
			row_cnt_r  <= '0;
			b_loaded_r <= 1'b0;
		end
		else begin
			state_r <= state_w;
			if (word_vld) begin
				if (!b_loaded_r) begin
					b_loaded_r <= 1'b1;  // rows follow, starting at row 0
				end
				else if (last_row) begin
					row_cnt_r <= '0;
					if (last_iter) begin
						// matrix solved, counters end at zero after the last one
						iter_cnt_r <= '0;
						b_loaded_r <= 1'b0;
						mat_cnt_r  <= last_mat ? '0 : mat_cnt_r + 1'b1;
					end
					else begin
						iter_cnt_r <= iter_cnt_r + 1'b1;
					end
				end
				else begin
					row_cnt_r <= row_cnt_r + 1'b1;
				end
			end
		end
	end

endmodule

// ==== row_engine/gs_row_update.sv ====
// gs_row_update: b and x storage, saturating Gauss-Seidel row update and result write
`timescale 1ns/1ps

module gs_row_update import gs_pkg::*; (
	input  logic                i_clk,
	input  logic                i_reset,
	gs_row_if.eng               row,
	output logic                o_x_wen,
	output logic [X_ADDR_W-1:0] o_x_addr,
	output logic [X_W-1:0]      o_x_data
);

	logic signed [ELEM_W-1:0] b_r [N_DIM];
	x_vec_t                   x_r;

	logic signed [ACC_W-1:0]  off_sum;      // sum of a_ij * x_j, j != i
	logic signed [ELEM_W-1:0] inv_aii;
	logic signed [ELEM_W-1:0] b_sel;
	logic signed [ACC_W-1:0]  b_scaled;
	logic signed [ACC_W-1:0]  resid;
	logic signed [X_W-1:0]    resid_sat;
	logic signed [PROD_W-1:0] scaled_prod;
	logic signed [X_W-1:0]    x_new;

	logic b_load;
	logic row_upd;
	logic final_wr;

	// clamp a wide signed value to the 32 bit x range
	function automatic logic signed [X_W-1:0] sat_x(input logic signed [ACC_W-1:0] v);
		logic signed [ACC_W-1:0] hi;
		logic signed [ACC_W-1:0] lo;
		hi = ACC_W'(X_MAX);
		lo = ACC_W'(X_MIN);
		if (v > hi) begin
			return X_MAX;
		end
		else if (v < lo) begin
			return X_MIN;
		end
		return v[X_W-1:0];
	endfunction

	// ---------------------------------------------------------------------------
	// word decode
	// ---------------------------------------------------------------------------
	assign b_load   = row.vld && (row.kind == WORD_B);
	assign row_upd  = row.vld && (row.kind == WORD_ROW);
	assign final_wr = row_upd && row.last_iter;

	gs_dot_product u_dot (
		.i_row     (row.data),
		.i_row_idx (row.row_idx),
		.i_x       (x_r),
		.o_sum     (off_sum),
		.o_inv     (inv_aii)
	);

	// ---------------------------------------------------------------------------
	// x_i = sat(sat((b_i << 16) - sum) * inv >>> 14)
	// ---------------------------------------------------------------------------
	assign b_sel     = b_r[row.row_idx];
	assign b_scaled  = ACC_W'(b_sel) <<< FRAC_W;  // b_i into Q16.16
	assign resid     = b_scaled - off_sum;
	assign resid_sat = sat_x(resid);

	// Q16.16 times 1/a_ii in Q2.14
	assign scaled_prod = resid_sat * inv_aii;
	assign x_new       = sat_x(ACC_W'(scaled_prod >>> INV_SHIFT));

	// ---------------------------------------------------------------------------
	// b and x storage
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (b_load) begin
			for (int i = 0; i < N_DIM; i++) begin
				b_r[i] <= row.data[i*ELEM_W +: ELEM_W];
				x_r[i] <= '0;  // every matrix starts from x = 0
			end
		end
		else if (row_upd) begin
			x_r[row.row_idx] <= x_new;  // newest x used by the next row
		end
	end

	// ---------------------------------------------------------------------------
	// result write, final sweep only
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_x_wen <= 1'b0;
		end
		else begin
			o_x_wen <= final_wr;
		end
	end

	always_ff @(posedge i_clk) begin
		if (final_wr) begin
			o_x_addr <= {row.mat_idx, row.row_idx};  // matrix * 16 + row
			o_x_data <= x_new;
		end
	end

endmodule

// ==== row_engine/gs_dot_product.sv ====
// gs_dot_product: sixteen lane signed row times x sum with the diagonal lane left out
`timescale 1ns/1ps

module gs_dot_product import gs_pkg::*; (
	input  mem_word_t                i_row,
	input  logic [ROW_W-1:0]         i_row_idx,
	input  x_vec_t                   i_x,
	output logic signed [ACC_W-1:0]  o_sum,
	output logic signed [ELEM_W-1:0] o_inv
);

	logic signed [ELEM_W-1:0] a_elem [N_DIM];
	logic signed [PROD_W-1:0] prod   [N_DIM];

	// ---------------------------------------------------------------------------
	// one multiplier per lane
	// ---------------------------------------------------------------------------
	for (genvar j = 0; j < N_DIM; j++) begin : g_lane
		assign a_elem[j] = i_row[j*ELEM_W +: ELEM_W];
		assign prod[j]   = a_elem[j] * i_x[j];  // 16 x 32 signed
	end

	// ---------------------------------------------------------------------------
	// adder over the off-diagonal lanes
	// ---------------------------------------------------------------------------
	always_comb begin
		o_sum = '0;
		for (int j = 0; j < N_DIM; j++) begin
			if (j != int'(i_row_idx)) begin
				o_sum = o_sum + ACC_W'(prod[j]);
			end
		end
	end

	// diagonal lane carries 1/a_ii scaled by 2^14
	assign o_inv = a_elem[i_row_idx];

endmodule

// ==== common/gs_row_if.sv ====
// gs_row_if: fetched memory word with its kind and indices, sequencer to row engine
`timescale 1ns/1ps

interface gs_row_if import gs_pkg::*; ();

	logic             vld;        // one cycle pulse, no back-pressure
	word_kind_t       kind;
	logic [ROW_W-1:0] row_idx;
	logic [MAT_W-1:0] mat_idx;
	logic             last_iter;  // final sweep, results go out
	mem_word_t        data;

	modport seq (
		output vld,
		output kind,
		output row_idx,
		output mat_idx,
		output last_iter,
		output data
	);

	modport eng (
		input vld,
		input kind,
		input row_idx,
		input mat_idx,
		input last_iter,
		input data
	);

endinterface

// ==== common/gs_pkg.sv ====
// gs_pkg: widths, counts, number formats and types shared by the Gauss-Seidel solver

package gs_pkg;

	// ---------------------------------------------------------------------------
	// problem size and number formats
	// ---------------------------------------------------------------------------
	localparam int N_DIM     = 16;  // rows and columns per matrix
	localparam int ELEM_W    = 16;  // a_ij, 1/a_ii and b_i elements
	localparam int X_W       = 32;  // x in Q16.16
	localparam int FRAC_W    = 16;
	localparam int INV_SHIFT = 14;  // 1/a_ii is stored scaled by 2^14
	localparam int PROD_W    = 48;  // 16 x 32 signed product
	localparam int ACC_W     = 52;  // sum of 15 products plus headroom

	// ---------------------------------------------------------------------------
	// iteration and memory layout
	// ---------------------------------------------------------------------------
	localparam int ITER_COUNT    = 16;  // fixed number of sweeps
	localparam int WORDS_PER_MAT = 17;  // 16 rows then b
	localparam int B_WORD        = 16;
	localparam int MEM_ADDR_W    = 10;
	localparam int X_ADDR_W      = 9;
	localparam int MAT_W         = 5;
	localparam int ROW_W         = 4;

	// saturation limits of a 32 bit signed x
	localparam logic signed [X_W-1:0] X_MAX = 32'sh7fff_ffff;
	localparam logic signed [X_W-1:0] X_MIN = 32'sh8000_0000;

	// one matrix memory word, sixteen 16 bit lanes
	typedef logic [N_DIM*ELEM_W-1:0] mem_word_t;

	// current solution vector
	typedef logic signed [X_W-1:0] x_vec_t [N_DIM];

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,     // read request held until ready
		ST_WAIT,    // waiting for data valid
		ST_FINISH   // done until enable drops
	} seq_state_t;

	typedef enum logic {
		WORD_B,
		WORD_ROW
	} word_kind_t;

endpackage
